// File: list.f
+incdir+include
verilog/simt_pkg.sv
verilog/banked_register_file.sv
verilog/operand_collector.sv
verilog/lane_alu.sv
verilog/operand_stage_top.sv
tests/tb_operand_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the operand stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f list.f --top-module tb_operand_stage -o sim_tb

# The simulator exits non-zero on a fatal error; the output search decides the result
output=$(./obj_dir/sim_tb 2>&1 || true)
echo "$output"

if echo "$output" | grep -qF ">>> PASS"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// File: include/tb_operand_stage_cases.svh
// Instruction cases for the operand stage testbench
// Warp id is the low two bits of the tag; register numbers assume 2 banks

// Columns of each add_case call
//   name, tag, pc, act_mask, op, dst, src_required, src0, src1, hold cycles
// src_required bit 0 is src0; a clear bit turns that source into an immediate

task automatic load_case_table;
    // ####################
    // Register-register, one per opcode
    // ####################
    add_case("add_w0",      4'h0, 16'h0100, 4'hf, simt_pkg::ADD,    4'd3,  2'b11, 4'd1,  4'd2,  0);
    add_case("sub_w1",      4'h5, 16'h0104, 4'hf, simt_pkg::SUB,    4'd4,  2'b11, 4'd5,  4'd6,  0);
    add_case("and_w2",      4'ha, 16'h0108, 4'hf, simt_pkg::AND,    4'd5,  2'b11, 4'd7,  4'd8,  0);
    add_case("or_w3",       4'hf, 16'h010c, 4'hf, simt_pkg::OR,     4'd6,  2'b11, 4'd9,  4'd10, 0);
    add_case("xor_w0",      4'h4, 16'h0110, 4'hf, simt_pkg::XOR,    4'd7,  2'b11, 4'd11, 4'd12, 0);
    add_case("pass_w1",     4'h9, 16'h0114, 4'hf, simt_pkg::PASS_A, 4'd8,  2'b11, 4'd13, 4'd14, 0);

    // Immediates
    add_case("imm_src1_w2", 4'h2, 16'h0118, 4'hf, simt_pkg::ADD,    4'd9,  2'b01, 4'd1,  4'd7,  0);
    add_case("imm_src0_w3", 4'h7, 16'h011c, 4'hf, simt_pkg::SUB,    4'd10, 2'b10, 4'd3,  4'd2,  0);
    add_case("imm_both_w0", 4'h0, 16'h0120, 4'hf, simt_pkg::ADD,    4'd1,  2'b00, 4'd5,  4'd9,  0);

    // Both sources in one bank
    add_case("conflict_w3", 4'hb, 16'h0124, 4'hf, simt_pkg::ADD,    4'd11, 2'b11, 4'd2,  4'd4,  0);
    add_case("conflict_w1", 4'h1, 16'h0128, 4'hf, simt_pkg::XOR,    4'd12, 2'b11, 4'd5,  4'd9,  0);

    // Partial mask, then read r13 back in full
    add_case("mask_w0",     4'h8, 16'h012c, 4'h5, simt_pkg::ADD,    4'd13, 2'b11, 4'd1,  4'd2,  0);
    add_case("readback_w0", 4'hc, 16'h0130, 4'hf, simt_pkg::PASS_A, 4'd14, 2'b11, 4'd13, 4'd0,  0);

    // ####################
    // Back-pressure and dependency
    // ####################
    add_case("hold_w2",     4'h6, 16'h0134, 4'hf, simt_pkg::XOR,    4'd15, 2'b11, 4'd3,  4'd4,  5);
    add_case("dep_a_w1",    4'hd, 16'h0138, 4'hf, simt_pkg::ADD,    4'd2,  2'b11, 4'd0,  4'd1,  0);
    add_case("dep_b_w1",    4'h1, 16'h013c, 4'hf, simt_pkg::SUB,    4'd3,  2'b11, 4'd2,  4'd6,  3);
    add_case("mask_hold_w3", 4'h3, 16'h0140, 4'ha, simt_pkg::OR,    4'd0,  2'b11, 4'd14, 4'd15, 2);
endtask

// File: tests/tb_operand_stage.sv
// Table-driven testbench for operand_stage_top with the default two banks
// Each case waits for the previous result; a held result overlaps the next dispatch
`timescale 1ns/1ps

module tb_operand_stage;

    localparam int NUM_CASES      = 17;
    localparam int LANE_W         = simt_pkg::REG_WIDTH;
    localparam int PRELOAD_CYCLES = simt_pkg::NUM_WARPS * simt_pkg::NUM_REGS;
    localparam int WATCHDOG_CYCLES = NUM_CASES * 40 + PRELOAD_CYCLES + 16;

    logic                 clk_i;
    logic                 rst_i;
    logic                 disp_valid_i;
    simt_pkg::dispatch_t  disp_i;
    logic                 disp_ready_o;
    logic                 init_wb_valid_i;
    simt_pkg::wb_req_t    init_wb_i;
    logic                 result_valid_o;
    simt_pkg::result_t    result_o;
    simt_pkg::warp_data_t result_data_o;
    logic                 result_ready_i;

    // Shadow of every warp register
    simt_pkg::warp_data_t shadow_q [simt_pkg::NUM_WARPS][simt_pkg::NUM_REGS];
    integer               seed;

    // Case table
    string                case_name [NUM_CASES];
    simt_pkg::dispatch_t  case_disp [NUM_CASES];
    int                   case_hold [NUM_CASES];
    simt_pkg::result_t    case_exp  [NUM_CASES];
    int                   case_count;

    // Next case already accepted while the previous result was held
    logic                 next_sent;

    operand_stage_top #(
        .NumBanks (2)
    ) UUT (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .disp_valid_i    (disp_valid_i),
        .disp_i          (disp_i),
        .disp_ready_o    (disp_ready_o),
        .init_wb_valid_i (init_wb_valid_i),
        .init_wb_i       (init_wb_i),
        .result_valid_o  (result_valid_o),
        .result_o        (result_o),
        .result_data_o   (result_data_o),
        .result_ready_i  (result_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_result(input string name, input simt_pkg::result_t exp,
                                input simt_pkg::result_t act);
        if (exp !== act) begin
            $display("Fail %s: expected header %h, actual %h", name, exp, act);
            stop_on_error("result header mismatch");
        end
    endtask

    task automatic check_data(input string name, input simt_pkg::warp_data_t exp,
                              input simt_pkg::warp_data_t act);
        if (exp !== act) begin
            $display("Fail %s: expected data %h, actual %h", name, exp, act);
            stop_on_error("result data mismatch");
        end
    endtask

    // Header echoes tag, pc and dst of the dispatch
    task automatic add_case(input string name, input simt_pkg::iid_t tag,
                            input simt_pkg::pc_t pc, input simt_pkg::act_mask_t mask,
                            input simt_pkg::alu_op_e op, input simt_pkg::reg_idx_t dst,
                            input logic [simt_pkg::OPERANDS_PER_INST-1:0] req,
                            input simt_pkg::reg_idx_t src0, input simt_pkg::reg_idx_t src1,
                            input int hold);
        simt_pkg::dispatch_t d;
        d.tag          = tag;
        d.pc           = pc;
        d.act_mask     = mask;
        d.op           = op;
        d.dst          = dst;
        d.src_required = req;
        d.src[0]       = src0;
        d.src[1]       = src1;
        case_name[case_count]     = name;
        case_disp[case_count]     = d;
        case_hold[case_count]     = hold;
        case_exp[case_count].tag  = tag;
        case_exp[case_count].pc   = pc;
        case_exp[case_count].dst  = dst;
        case_count++;
    endtask

    `include "tb_operand_stage_cases.svh"

    // ####################
    // Reference model
    // ####################

    function automatic simt_pkg::lane_data_t lane_op(input simt_pkg::alu_op_e op,
                                                     input simt_pkg::lane_data_t a,
                                                     input simt_pkg::lane_data_t b);
        case (op)
            simt_pkg::ADD:    return a + b;
            simt_pkg::SUB:    return a - b;
            simt_pkg::AND:    return a & b;
            simt_pkg::OR:     return a | b;
            simt_pkg::XOR:    return a ^ b;
            simt_pkg::PASS_A: return a;
            default:          return '0;
        endcase
    endfunction

    // Register operands from the shadow, immediates as the index in every lane
    function automatic simt_pkg::warp_data_t expected_data(input simt_pkg::dispatch_t d);
        simt_pkg::wid_t       wid;
        simt_pkg::warp_data_t opnd [simt_pkg::OPERANDS_PER_INST];
        simt_pkg::warp_data_t res;
        wid = d.tag[simt_pkg::WID_WIDTH-1:0];
        for (int i = 0; i < simt_pkg::OPERANDS_PER_INST; i++) begin
            if (d.src_required[i]) begin
                opnd[i] = shadow_q[wid][d.src[i]];
            end else begin
                opnd[i] = {simt_pkg::WARP_WIDTH{simt_pkg::lane_data_t'(d.src[i])}};
            end
        end
        res = '0;
        for (int l = 0; l < simt_pkg::WARP_WIDTH; l++) begin
            if (d.act_mask[l]) begin
                res[l*LANE_W +: LANE_W] = lane_op(d.op, opnd[0][l*LANE_W +: LANE_W],
                                                  opnd[1][l*LANE_W +: LANE_W]);
            end
        end
        return res;
    endfunction

    // Random preload of every register through the init port
    task automatic preload_registers;
        simt_pkg::warp_data_t data;
        logic [31:0]          r;
        for (int w = 0; w < simt_pkg::NUM_WARPS; w++) begin
            for (int g = 0; g < simt_pkg::NUM_REGS; g++) begin
                for (int l = 0; l < simt_pkg::WARP_WIDTH; l++) begin
                    r = $random(seed);
                    data[l*LANE_W +: LANE_W] = r[LANE_W-1:0];
                end
                init_wb_valid_i    = 1'b1;
                init_wb_i.wid      = simt_pkg::wid_t'(w);
                init_wb_i.reg_idx  = simt_pkg::reg_idx_t'(g);
                init_wb_i.act_mask = '1;
                init_wb_i.data     = data;
                shadow_q[w][g]     = data;
                @(posedge clk_i);
                #1;
            end
        end
        init_wb_valid_i = 1'b0;
    endtask

    task automatic run_case(input int idx);
        simt_pkg::dispatch_t  d;
        simt_pkg::wid_t       wid;
        simt_pkg::warp_data_t exp_data;
        simt_pkg::result_t    held_hdr;
        simt_pkg::warp_data_t held_data;
        logic                 overlap;
        d        = case_disp[idx];
        wid      = d.tag[simt_pkg::WID_WIDTH-1:0];
        exp_data = expected_data(d);
        // Masked write into the shadow
        for (int l = 0; l < simt_pkg::WARP_WIDTH; l++) begin
            if (d.act_mask[l]) begin
                shadow_q[wid][d.dst][l*LANE_W +: LANE_W] = exp_data[l*LANE_W +: LANE_W];
            end
        end
        result_ready_i = (case_hold[idx] == 0);
        if (next_sent) begin
            next_sent = 1'b0;
        end else begin
            disp_valid_i   = 1'b1;
            disp_i         = d;
            while (!disp_ready_o) begin
                @(posedge clk_i);
                #1;
            end
            @(posedge clk_i);
            #1;
            disp_valid_i = 1'b0;
        end
        while (!result_valid_o) begin
            @(posedge clk_i);
            #1;
        end
        check_result(case_name[idx], case_exp[idx], result_o);
        check_data(case_name[idx], exp_data, result_data_o);
        held_hdr  = result_o;
        held_data = result_data_o;
        // Next instruction goes in while this result is stalled
        overlap = (case_hold[idx] > 0) && (idx + 1 < case_count);
        if (overlap) begin
            if (!disp_ready_o) begin
                stop_on_error({case_name[idx], " collector still busy after the exec transfer"});
            end
            disp_valid_i = 1'b1;
            disp_i       = case_disp[idx + 1];
        end
        // Output must hold steady while stalled
        for (int h = 0; h < case_hold[idx]; h++) begin
            @(posedge clk_i);
            #1;
            disp_valid_i = 1'b0;
            if (!result_valid_o) begin
                stop_on_error({case_name[idx], " result valid dropped under back-pressure"});
            end
            check_result({case_name[idx], "_hold"}, held_hdr, result_o);
            check_data({case_name[idx], "_hold"}, held_data, result_data_o);
            // Stalled ALU keeps the collector full
            if (overlap && disp_ready_o) begin
                stop_on_error({case_name[idx], " dispatch ready under back-pressure"});
            end
        end
        next_sent      = overlap;
        result_ready_i = 1'b1;
        @(posedge clk_i);
        #1;
        // A result loaded on this edge belongs to the next case
        if (result_valid_o && (!overlap || result_o === held_hdr)) begin
            stop_on_error({case_name[idx], " result still valid after it was accepted"});
        end
    endtask

    // ####################
    // Main sequence
    // ####################

    initial begin
        seed            = 11853;
        case_count      = 0;
        next_sent       = 1'b0;
        rst_i           = 1'b1;
        disp_valid_i    = 1'b0;
        disp_i          = '0;
        init_wb_valid_i = 1'b0;
        init_wb_i       = '0;
        result_ready_i  = 1'b1;
        load_case_table();
        repeat (16) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        if (!disp_ready_o || result_valid_o) begin
            stop_on_error("handshake outputs wrong after reset");
        end
        preload_registers();
        for (int i = 0; i < case_count; i++) begin
            run_case(i);
        end
        $display(">>> PASS");
        $finish;
    end

    // Watchdog sized from case count and preload length
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout, the DUT did not finish the cases in time");
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: verilog/banked_register_file.sv
// Vector register file, banked on the low bits of the register index
// NumBanks of 2 or 4; one read per bank per cycle, data one cycle later
`timescale 1ns/1ps

module banked_register_file #(
    parameter int unsigned NumBanks = 2
) (
    input  logic clk_i,
    input  logic rst_i,

    // Read request per operand channel
    input  logic [simt_pkg::OPERANDS_PER_INST-1:0]                 rd_valid_i,
    input  simt_pkg::read_req_t [simt_pkg::OPERANDS_PER_INST-1:0]  rd_req_i,
    output logic [simt_pkg::OPERANDS_PER_INST-1:0]                 rd_ready_o,

    // Response, one cycle after the accepted request
    output logic [simt_pkg::OPERANDS_PER_INST-1:0]                 rd_rsp_valid_o,
    output simt_pkg::warp_data_t [simt_pkg::OPERANDS_PER_INST-1:0] rd_rsp_data_o,

    // Write ports, ALU wins on collision
    input  logic                                                   init_wb_valid_i,
    input  simt_pkg::wb_req_t                                      init_wb_i,
    input  logic                                                   alu_wb_valid_i,
    input  simt_pkg::wb_req_t                                      alu_wb_i
);

    localparam int unsigned NumOps    = simt_pkg::OPERANDS_PER_INST;
    localparam int unsigned BankBits  = $clog2(NumBanks);
    localparam int unsigned RowBits   = simt_pkg::REG_IDX_WIDTH - BankBits;
    localparam int unsigned BankDepth = simt_pkg::NUM_WARPS << RowBits;
    localparam int unsigned LaneW     = simt_pkg::REG_WIDTH;

    typedef logic [BankBits-1:0]                     bank_idx_t;
    typedef logic [simt_pkg::WID_WIDTH+RowBits-1:0]  row_addr_t;

    function automatic bank_idx_t bank_of(simt_pkg::reg_idx_t idx);
        return idx[BankBits-1:0];
    endfunction

    // Row inside a bank is warp id over the upper index bits
    function automatic row_addr_t row_of(simt_pkg::wid_t wid, simt_pkg::reg_idx_t idx);
        return {wid, idx[simt_pkg::REG_IDX_WIDTH-1:BankBits]};
    endfunction

    simt_pkg::warp_data_t bank_rd_data [NumBanks];
    logic [NumOps-1:0]    rsp_valid_q;
    bank_idx_t            rsp_bank_q [NumOps];

    // ####################
    // Read arbitration
    // ####################

    // Fixed priority, lower operand index wins its bank
    always_comb begin
        for (int i = 0; i < NumOps; i++) begin
            rd_ready_o[i] = rd_valid_i[i];
            for (int j = 0; j < i; j++) begin
                if (rd_valid_i[j] && bank_of(rd_req_i[j].reg_idx) == bank_of(rd_req_i[i].reg_idx)) begin
                    rd_ready_o[i] = 1'b0;
                end
            end
        end
    end

    // ####################
    // Banks
    // ####################

    for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
        simt_pkg::warp_data_t mem_q [BankDepth];
        simt_pkg::warp_data_t rd_q;
        logic                 rd_en;
        row_addr_t            rd_addr;
        logic                 init_hit;
        logic                 alu_hit;

        // At most one granted read lands here
        always_comb begin
            rd_en   = 1'b0;
            rd_addr = '0;
            for (int i = 0; i < NumOps; i++) begin
                if (rd_valid_i[i] && rd_ready_o[i] && bank_of(rd_req_i[i].reg_idx) == bank_idx_t'(b)) begin
                    rd_en   = 1'b1;
                    rd_addr = row_of(rd_req_i[i].wid, rd_req_i[i].reg_idx);
                end
            end
        end

        assign init_hit = init_wb_valid_i && bank_of(init_wb_i.reg_idx) == bank_idx_t'(b);
        assign alu_hit  = alu_wb_valid_i && bank_of(alu_wb_i.reg_idx) == bank_idx_t'(b);

        // Masked lane writes, ALU assigned last so it overrides init
        always_ff @(posedge clk_i) begin
            if (rd_en) begin
                rd_q <= mem_q[rd_addr];
            end
            for (int l = 0; l < simt_pkg::WARP_WIDTH; l++) begin
                if (init_hit && init_wb_i.act_mask[l]) begin
                    mem_q[row_of(init_wb_i.wid, init_wb_i.reg_idx)][l*LaneW +: LaneW] <=
                        init_wb_i.data[l*LaneW +: LaneW];
                end
                if (alu_hit && alu_wb_i.act_mask[l]) begin
                    mem_q[row_of(alu_wb_i.wid, alu_wb_i.reg_idx)][l*LaneW +: LaneW] <=
                        alu_wb_i.data[l*LaneW +: LaneW];
                end
            end
        end

        assign bank_rd_data[b] = rd_q;
    end

    // ####################
    // Response routing
    // ####################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rsp_valid_q <= '0;
        end else begin
            rsp_valid_q <= rd_valid_i & rd_ready_o;
        end
    end

    // Remember which bank each channel was served by
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < NumOps; i++) begin
            rsp_bank_q[i] <= bank_of(rd_req_i[i].reg_idx);
        end
    end

    assign rd_rsp_valid_o = rsp_valid_q;

    always_comb begin
        for (int i = 0; i < NumOps; i++) begin
            rd_rsp_data_o[i] = bank_rd_data[rsp_bank_q[i]];
        end
    end

endmodule

// File: verilog/lane_alu.sv
// Per-thread integer ALU with one output register
// Writeback strobe fires in the cycle the output register loads
`timescale 1ns/1ps

module lane_alu (
    input  logic clk_i,
    input  logic rst_i,

    // From the collector
    input  logic                 exec_valid_i,
    input  simt_pkg::exec_req_t  exec_req_i,
    output logic                 exec_ready_o,

    // Register write, single cycle strobe
    output logic                 wb_valid_o,
    output simt_pkg::wb_req_t    wb_o,

    // Result toward the outside
    output logic                 result_valid_o,
    output simt_pkg::result_t    result_o,
    output simt_pkg::warp_data_t result_data_o,
    input  logic                 result_ready_i
);

    localparam int unsigned LaneW = simt_pkg::REG_WIDTH;

    logic                 exec_fire;
    logic                 out_valid_q;
    simt_pkg::result_t    out_hdr_q;
    simt_pkg::warp_data_t out_data_q;
    simt_pkg::warp_data_t lane_res;

    // Accept when empty or being drained this cycle
    assign exec_ready_o = !out_valid_q || result_ready_i;
    assign exec_fire    = exec_valid_i && exec_ready_o;

    // ####################
    // Lane datapath
    // ####################

    always_comb begin
        simt_pkg::lane_data_t a;
        simt_pkg::lane_data_t b;
        for (int l = 0; l < simt_pkg::WARP_WIDTH; l++) begin
            a = exec_req_i.operands[0][l*LaneW +: LaneW];
            b = exec_req_i.operands[1][l*LaneW +: LaneW];
            unique case (exec_req_i.op)
                simt_pkg::ADD:    lane_res[l*LaneW +: LaneW] = a + b;
                simt_pkg::SUB:    lane_res[l*LaneW +: LaneW] = a - b;
                simt_pkg::AND:    lane_res[l*LaneW +: LaneW] = a & b;
                simt_pkg::OR:     lane_res[l*LaneW +: LaneW] = a | b;
                simt_pkg::XOR:    lane_res[l*LaneW +: LaneW] = a ^ b;
                simt_pkg::PASS_A: lane_res[l*LaneW +: LaneW] = a;
                default:          lane_res[l*LaneW +: LaneW] = '0;
            endcase
            // Inactive threads read as zero
            if (!exec_req_i.act_mask[l]) begin
                lane_res[l*LaneW +: LaneW] = '0;
            end
        end
    end

    // Masked write back to the register file
    assign wb_valid_o  = exec_fire;
    assign wb_o.wid      = exec_req_i.tag[simt_pkg::WID_WIDTH-1:0];
    assign wb_o.reg_idx  = exec_req_i.dst;
    assign wb_o.act_mask = exec_req_i.act_mask;
    assign wb_o.data     = lane_res;

    // ####################
    // Output register
    // ####################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_valid_q <= 1'b0;
        end else if (exec_fire) begin
            out_valid_q <= 1'b1;
        end else if (result_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    // Held while stalled, only loads on a new instruction
    always_ff @(posedge clk_i) begin
        if (exec_fire) begin
            out_hdr_q.tag <= exec_req_i.tag;
            out_hdr_q.pc  <= exec_req_i.pc;
            out_hdr_q.dst <= exec_req_i.dst;
            out_data_q    <= lane_res;
        end
    end

    assign result_valid_o = out_valid_q;
    assign result_o       = out_hdr_q;
    assign result_data_o  = out_data_q;

endmodule

// File: verilog/operand_collector.sv
// Single-slot collector, holds one instruction until the execution stage takes it
// Register file must answer exactly one cycle after each accepted read
`timescale 1ns/1ps

module operand_collector (
    input  logic clk_i,
    input  logic rst_i,

    // Dispatch side
    input  logic                                                 disp_valid_i,
    input  simt_pkg::dispatch_t                                  disp_i,
    output logic                                                 disp_ready_o,

    // Register file read request per operand
    output logic [simt_pkg::OPERANDS_PER_INST-1:0]               rd_valid_o,
    output simt_pkg::read_req_t [simt_pkg::OPERANDS_PER_INST-1:0] rd_req_o,
    input  logic [simt_pkg::OPERANDS_PER_INST-1:0]               rd_ready_i,

    // Register file response, fixed one cycle latency
    input  logic [simt_pkg::OPERANDS_PER_INST-1:0]               rd_rsp_valid_i,
    input  simt_pkg::warp_data_t [simt_pkg::OPERANDS_PER_INST-1:0] rd_rsp_data_i,

    // Execution side
    output logic                                                 exec_valid_o,
    output simt_pkg::exec_req_t                                  exec_req_o,
    input  logic                                                 exec_ready_i
);

    localparam int unsigned NumOps = simt_pkg::OPERANDS_PER_INST;

    // ####################
    // Slot state
    // ####################

    // Control flags, cleared by reset
    logic              occupied_q;
    logic [NumOps-1:0] requested_q;
    logic [NumOps-1:0] ready_q;

    // Payload, no reset needed
    simt_pkg::dispatch_t                 inst_q;
    simt_pkg::warp_data_t [NumOps-1:0]   data_q;

    logic disp_fire;
    logic exec_fire;

    assign disp_ready_o = !occupied_q;
    assign disp_fire    = disp_valid_i && disp_ready_o;
    assign exec_valid_o = occupied_q && (&ready_q);
    assign exec_fire    = exec_valid_o && exec_ready_i;

    // Read requests go out from the cycle after acceptance
    always_comb begin
        for (int i = 0; i < NumOps; i++) begin
            rd_valid_o[i]       = occupied_q && !requested_q[i];
            // Warp id is the low part of the tag
            rd_req_o[i].wid     = inst_q.tag[simt_pkg::WID_WIDTH-1:0];
            rd_req_o[i].reg_idx = inst_q.src[i];
        end
    end

    // Flag updates
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            occupied_q  <= 1'b0;
            requested_q <= '0;
            ready_q     <= '0;
        end else if (disp_fire) begin
            occupied_q  <= 1'b1;
            // Immediate operands count as already fetched
            requested_q <= ~disp_i.src_required;
            ready_q     <= ~disp_i.src_required;
        end else begin
            if (exec_fire) begin
                occupied_q <= 1'b0;
            end
            // Sticky once the handshake or response happens
            requested_q <= requested_q | (rd_valid_o & rd_ready_i);
            ready_q     <= ready_q | rd_rsp_valid_i;
        end
    end

    // Instruction and operand data
    always_ff @(posedge clk_i) begin
        if (disp_fire) begin
            inst_q <= disp_i;
        end
        for (int i = 0; i < NumOps; i++) begin
            if (disp_fire && !disp_i.src_required[i]) begin
                // Immediate, source index in every lane
                for (int l = 0; l < simt_pkg::WARP_WIDTH; l++) begin
                    data_q[i][l*simt_pkg::REG_WIDTH +: simt_pkg::REG_WIDTH] <=
                        simt_pkg::lane_data_t'(disp_i.src[i]);
                end
            end else if (rd_rsp_valid_i[i]) begin
                data_q[i] <= rd_rsp_data_i[i];
            end
        end
    end

    // Collected instruction toward the ALU
    assign exec_req_o.tag      = inst_q.tag;
    assign exec_req_o.pc       = inst_q.pc;
    assign exec_req_o.act_mask = inst_q.act_mask;
    assign exec_req_o.op       = inst_q.op;
    assign exec_req_o.dst      = inst_q.dst;
    assign exec_req_o.operands = data_q;

endmodule

// File: verilog/operand_stage_top.sv
// Operand stage, collector feeding a lane ALU over a banked register file
// One instruction in flight; init port preloads registers for test
`timescale 1ns/1ps

module operand_stage_top #(
    parameter int unsigned NumBanks = 2
) (
    input  logic clk_i,
    input  logic rst_i,

    // Dispatch in
    input  logic                 disp_valid_i,
    input  simt_pkg::dispatch_t  disp_i,
    output logic                 disp_ready_o,

    // Direct register preload
    input  logic                 init_wb_valid_i,
    input  simt_pkg::wb_req_t    init_wb_i,

    // Result out
    output logic                 result_valid_o,
    output simt_pkg::result_t    result_o,
    output simt_pkg::warp_data_t result_data_o,
    input  logic                 result_ready_i
);

    localparam int unsigned NumOps = simt_pkg::OPERANDS_PER_INST;

    // Collector to register file
    logic [NumOps-1:0]                 rd_valid;
    simt_pkg::read_req_t [NumOps-1:0]  rd_req;
    logic [NumOps-1:0]                 rd_ready;
    logic [NumOps-1:0]                 rd_rsp_valid;
    simt_pkg::warp_data_t [NumOps-1:0] rd_rsp_data;

    // Collector to ALU
    logic                exec_valid;
    simt_pkg::exec_req_t exec_req;
    logic                exec_ready;

    // ALU writeback
    logic                alu_wb_valid;
    simt_pkg::wb_req_t   alu_wb;

    operand_collector u_collector (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .disp_valid_i   (disp_valid_i),
        .disp_i         (disp_i),
        .disp_ready_o   (disp_ready_o),
        .rd_valid_o     (rd_valid),
        .rd_req_o       (rd_req),
        .rd_ready_i     (rd_ready),
        .rd_rsp_valid_i (rd_rsp_valid),
        .rd_rsp_data_i  (rd_rsp_data),
        .exec_valid_o   (exec_valid),
        .exec_req_o     (exec_req),
        .exec_ready_i   (exec_ready)
    );

    banked_register_file #(
        .NumBanks (NumBanks)
    ) u_regfile (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .rd_valid_i      (rd_valid),
        .rd_req_i        (rd_req),
        .rd_ready_o      (rd_ready),
        .rd_rsp_valid_o  (rd_rsp_valid),
        .rd_rsp_data_o   (rd_rsp_data),
        .init_wb_valid_i (init_wb_valid_i),
        .init_wb_i       (init_wb_i),
        .alu_wb_valid_i  (alu_wb_valid),
        .alu_wb_i        (alu_wb)
    );

    lane_alu u_alu (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .exec_valid_i   (exec_valid),
        .exec_req_i     (exec_req),
        .exec_ready_o   (exec_ready),
        .wb_valid_o     (alu_wb_valid),
        .wb_o           (alu_wb),
        .result_valid_o (result_valid_o),
        .result_o       (result_o),
        .result_data_o  (result_data_o),
        .result_ready_i (result_ready_i)
    );

endmodule

// File: verilog/simt_pkg.sv
// Widths and shared types of the operand stage
// Sizes are fixed here; only the register file bank count is a parameter
package simt_pkg;

    // Warps, threads and register geometry
    localparam int unsigned NUM_WARPS         = 4;
    localparam int unsigned WID_WIDTH         = 2;
    localparam int unsigned WARP_WIDTH        = 4;
    localparam int unsigned REG_WIDTH         = 16;
    localparam int unsigned NUM_REGS          = 16;
    localparam int unsigned REG_IDX_WIDTH     = 4;
    localparam int unsigned OPERANDS_PER_INST = 2;
    localparam int unsigned TAG_WIDTH         = 2;
    localparam int unsigned PC_WIDTH          = 16;

    typedef logic [WID_WIDTH-1:0]              wid_t;
    typedef logic [REG_IDX_WIDTH-1:0]          reg_idx_t;
    typedef logic [PC_WIDTH-1:0]               pc_t;
    typedef logic [WARP_WIDTH-1:0]             act_mask_t;
    typedef logic [REG_WIDTH-1:0]              lane_data_t;
    typedef logic [WARP_WIDTH*REG_WIDTH-1:0]   warp_data_t;
    // Warp id sits in the low bits
    typedef logic [TAG_WIDTH+WID_WIDTH-1:0]    iid_t;

    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        AND    = 3'd2,
        OR     = 3'd3,
        XOR    = 3'd4,
        PASS_A = 3'd5
    } alu_op_e;

    // ####################
    // Packed bundles
    // ####################

    typedef struct packed {
        iid_t                                  tag;
        pc_t                                   pc;
        act_mask_t                             act_mask;
        alu_op_e                               op;
        reg_idx_t                              dst;
        logic [OPERANDS_PER_INST-1:0]          src_required;
        reg_idx_t [OPERANDS_PER_INST-1:0]      src;
    } dispatch_t;

    typedef struct packed {
        wid_t     wid;
        reg_idx_t reg_idx;
    } read_req_t;

    typedef struct packed {
        iid_t                                  tag;
        pc_t                                   pc;
        act_mask_t                             act_mask;
        alu_op_e                               op;
        reg_idx_t                              dst;
        warp_data_t [OPERANDS_PER_INST-1:0]    operands;
    } exec_req_t;

    typedef struct packed {
        wid_t       wid;
        reg_idx_t   reg_idx;
        act_mask_t  act_mask;
        warp_data_t data;
    } wb_req_t;

    typedef struct packed {
        iid_t     tag;
        pc_t      pc;
        reg_idx_t dst;
    } result_t;

endpackage
